//--- all.f
gfx_bus_pkg.sv
gfx_video_pkg.sv
mpu_port.sv
tile_fetcher.sv
pixel_fifo.sv
scan_out.sv
gfx_top.sv
gfx_props.sv
tb_gfx.sv

//--- gfx_bus_pkg.sv
/* MPU bus types, memory map and register indices,
   address region enum, memory-write packet and byte merge helper */
package gfx_bus_pkg;

  typedef logic [15:0] mpu_addr_t;   // Word address
  typedef logic [15:0] mpu_data_t;
  typedef logic [1:0]  byte_en_t;    // Active high inside the design
  typedef logic [7:0]  mem_offset_t; // Word offset within a region

  // Memory map in words
  localparam mpu_addr_t REG_BASE  = 16'h0000;
  localparam mpu_addr_t REG_LEN   = 16'd4;
  localparam mpu_addr_t PAL_BASE  = 16'h0100;
  localparam mpu_addr_t PAL_LEN   = 16'd16;
  localparam mpu_addr_t MAP_BASE  = 16'h0200;
  localparam mpu_addr_t MAP_LEN   = 16'd8;
  localparam mpu_addr_t VRAM_BASE = 16'h1000;
  localparam mpu_addr_t VRAM_LEN  = 16'd256;

  localparam mem_offset_t REG_CTRL   = 8'd0;  // Bit 0 is display enable
  localparam mem_offset_t REG_STATUS = 8'd1;  // Read only
  localparam mem_offset_t REG_FRAMES = 8'd2;  // Read only

  typedef enum logic [2:0] {
    REGION_NONE,
    REGION_REGS,
    REGION_PAL,
    REGION_MAP,
    REGION_VRAM
  } region_e;

  typedef struct packed {
    logic        we;
    region_e     region;
    mem_offset_t offset;
    mpu_data_t   data;
    byte_en_t    be;
  } mem_write_t;

  // Byte lanes of new_word replace those of old_word where be is set
  function automatic mpu_data_t merge_bytes(mpu_data_t old_word, mpu_data_t new_word,
                                            byte_en_t be);
    mpu_data_t merged;
    merged = old_word;
    if (be[0]) merged[7:0] = new_word[7:0];
    if (be[1]) merged[15:8] = new_word[15:8];
    return merged;
  endfunction

endpackage

//--- gfx_props.sv
/* Concurrent checks on sync windows, sync periods, blanking and FIFO
   underrun against a raster position model, bound into gfx_top */
`timescale 1ns/10ps

module gfx_props (
  input logic                clk,
  input logic                rst_n,
  input logic                vga_hsync,
  input logic                vga_vsync,
  input gfx_video_pkg::rgb_t vga_rgb,
  input logic                underrun
);

  gfx_video_pkg::hcount_t h_cnt;
  gfx_video_pkg::vcount_t v_cnt;
  gfx_video_pkg::hcount_t h_shown;  // Position the outputs describe
  gfx_video_pkg::vcount_t v_shown;
  logic                   in_hsync;
  logic                   in_vsync;
  logic                   shown_visible;
  logic                   hsync_q;
  logic                   vsync_q;
  logic                   hsync_fell;
  logic                   vsync_fell;
  logic                   hsync_seen;     // First fall starts the period count
  logic                   vsync_seen;
  int unsigned            hsync_gap;      // Clocks since the last fall
  int unsigned            vsync_gap;
  int unsigned            fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt   <= '0;
      v_cnt   <= gfx_video_pkg::V_RESET_LINE;
      h_shown <= '0;
      v_shown <= gfx_video_pkg::V_RESET_LINE;
    end else begin
      h_shown <= h_cnt;
      v_shown <= v_cnt;
      if (h_cnt == gfx_video_pkg::H_TOTAL - 1'b1) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == gfx_video_pkg::V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign in_hsync = (h_shown >= gfx_video_pkg::H_SYNC_START)
                 && (h_shown <= gfx_video_pkg::H_SYNC_END);
  assign in_vsync = (v_shown >= gfx_video_pkg::V_SYNC_START)
                 && (v_shown <= gfx_video_pkg::V_SYNC_END);
  assign shown_visible = (h_shown < gfx_video_pkg::H_ACTIVE)
                      && (v_shown < gfx_video_pkg::V_ACTIVE);

  assign hsync_fell = hsync_q && !vga_hsync;
  assign vsync_fell = vsync_q && !vga_vsync;

  // Distance between falling edges, independent of the position model
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync_q    <= 1'b1;
      vsync_q    <= 1'b1;
      hsync_seen <= 1'b0;
      vsync_seen <= 1'b0;
      hsync_gap  <= 0;
      vsync_gap  <= 0;
    end else begin
      hsync_q   <= vga_hsync;
      vsync_q   <= vga_vsync;
      hsync_gap <= hsync_fell ? 1 : hsync_gap + 1;
      vsync_gap <= vsync_fell ? 1 : vsync_gap + 1;
      if (hsync_fell)
        hsync_seen <= 1'b1;
      if (vsync_fell)
        vsync_seen <= 1'b1;
    end
  end

  hsync_window: assert property (@(posedge clk) disable iff (!rst_n)
    vga_hsync == !in_hsync)
    else begin
      fail_count++;
      $error("MISMATCH vga_hsync at h %0d line %0d: got %h expected %h",
             $sampled(h_shown), $sampled(v_shown), $sampled(vga_hsync),
             !$sampled(in_hsync));
    end

  vsync_window: assert property (@(posedge clk) disable iff (!rst_n)
    vga_vsync == !in_vsync)
    else begin
      fail_count++;
      $error("MISMATCH vga_vsync at h %0d line %0d: got %h expected %h",
             $sampled(h_shown), $sampled(v_shown), $sampled(vga_vsync),
             !$sampled(in_vsync));
    end

  line_period: assert property (@(posedge clk) disable iff (!rst_n)
    hsync_fell && hsync_seen |-> hsync_gap == int'(gfx_video_pkg::H_TOTAL))
    else begin
      fail_count++;
      $error("hsync fell %0d clocks after the previous fall", $sampled(hsync_gap));
    end

  frame_period: assert property (@(posedge clk) disable iff (!rst_n)
    vsync_fell && vsync_seen
      |-> vsync_gap == int'(gfx_video_pkg::V_TOTAL) * int'(gfx_video_pkg::H_TOTAL))
    else begin
      fail_count++;
      $error("vsync fell %0d clocks after the previous fall", $sampled(vsync_gap));
    end

  blanking: assert property (@(posedge clk) disable iff (!rst_n)
    !shown_visible |-> vga_rgb == '0)
    else begin
      fail_count++;
      $error("MISMATCH vga_rgb at h %0d line %0d: got %h expected 0",
             $sampled(h_shown), $sampled(v_shown), $sampled(vga_rgb));
    end

  no_underrun: assert property (@(posedge clk) disable iff (!rst_n) !underrun)
    else begin
      fail_count++;
      $error("pixel FIFO ran empty on a visible position");
    end

endmodule

bind gfx_top gfx_props props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .vga_hsync (vga_hsync),
  .vga_vsync (vga_vsync),
  .vga_rgb   (vga_rgb),
  .underrun  (underrun)
);

//--- gfx_top.sv
/* Top level: MPU port, tile fetcher, pixel FIFO and scan-out */
`timescale 1ns/10ps

module gfx_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   mpu_en_n,
  input  logic                   mpu_rd_n,
  input  logic                   mpu_wr_n,
  input  logic [1:0]             mpu_be_n,
  input  gfx_bus_pkg::mpu_addr_t mpu_addr,
  input  gfx_bus_pkg::mpu_data_t mpu_data_in,
  output gfx_bus_pkg::mpu_data_t mpu_data_out,
  output logic                   vga_hsync,
  output logic                   vga_vsync,
  output gfx_video_pkg::rgb_t    vga_rgb
);

  gfx_bus_pkg::mem_write_t    mem_wr;       // To all memories
  logic                       display_en;
  logic                       frame_start;
  logic                       underrun;
  logic                       push;
  gfx_video_pkg::pix_index_t  push_data;
  gfx_video_pkg::fifo_level_t fifo_level;
  logic                       pop;
  gfx_video_pkg::pix_index_t  pop_data;
  logic                       empty;

  mpu_port mpu_port_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mpu_en_n     (mpu_en_n),
    .mpu_rd_n     (mpu_rd_n),
    .mpu_wr_n     (mpu_wr_n),
    .mpu_be_n     (mpu_be_n),
    .mpu_addr     (mpu_addr),
    .mpu_data_in  (mpu_data_in),
    .mpu_data_out (mpu_data_out),
    .mem_wr       (mem_wr),
    .display_en   (display_en),
    .frame_start  (frame_start),
    .underrun     (underrun)
  );

  // Producer side
  tile_fetcher tile_fetcher_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_wr     (mem_wr),
    .push       (push),
    .push_data  (push_data),
    .fifo_level (fifo_level)
  );

  pixel_fifo pixel_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .level     (fifo_level)
  );

  // Consumer side
  scan_out scan_out_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_wr      (mem_wr),
    .display_en  (display_en),
    .pop_data    (pop_data),
    .empty       (empty),
    .pop         (pop),
    .frame_start (frame_start),
    .underrun    (underrun),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync),
    .vga_rgb     (vga_rgb)
  );

endmodule

//--- gfx_video_pkg.sv
/* Video package: raster geometry, tile and pattern geometry,
   pixel FIFO sizing, counter, pixel and colour types */
package gfx_video_pkg;

  typedef logic [5:0]  hcount_t;
  typedef logic [4:0]  vcount_t;
  typedef logic [3:0]  pix_index_t;   // Palette index
  typedef logic [3:0]  tile_index_t;  // Low bits of a tile map word
  typedef logic [15:0] rgb565_t;      // Stored palette colour
  typedef logic [17:0] rgb_t;         // 6:6:6 output colour

  // Raster, one pixel per clock
  localparam hcount_t H_ACTIVE     = 6'd32;
  localparam hcount_t H_TOTAL      = 6'd40;
  localparam hcount_t H_SYNC_START = 6'd34;
  localparam hcount_t H_SYNC_END   = 6'd36;  // Inclusive
  localparam vcount_t V_ACTIVE     = 5'd16;
  localparam vcount_t V_TOTAL      = 5'd20;
  localparam vcount_t V_SYNC_START = 5'd17;
  localparam vcount_t V_SYNC_END   = 5'd18;
  localparam vcount_t V_RESET_LINE = 5'd16;  // Blank lines to prefill the FIFO

  // Tiles of 8x8 pixels at 4 bits per pixel
  localparam int TILE_SIZE      = 8;
  localparam int MAP_COLS       = 4;
  localparam int MAP_ROWS       = 2;
  localparam int PIX_BITS       = 4;
  localparam int PIX_PER_WORD   = 4;
  localparam int WORDS_PER_ROW  = TILE_SIZE / PIX_PER_WORD;
  localparam int WORDS_PER_TILE = TILE_SIZE * WORDS_PER_ROW;
  localparam int MAP_ADDR_W     = $clog2(MAP_COLS * MAP_ROWS);

  typedef logic [MAP_ADDR_W-1:0] map_addr_t;

  localparam int FIFO_DEPTH = 8;

  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH):0]   fifo_level_t;  // Holds 0 to FIFO_DEPTH

endpackage

//--- mpu_port.sv
/* MPU port: address region decode, registered memory-write packet,
   ctrl/status/frames registers and the register read mux */
`timescale 1ns/10ps

module mpu_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    mpu_en_n,
  input  logic                    mpu_rd_n,
  input  logic                    mpu_wr_n,
  input  logic [1:0]              mpu_be_n,
  input  gfx_bus_pkg::mpu_addr_t  mpu_addr,
  input  gfx_bus_pkg::mpu_data_t  mpu_data_in,
  output gfx_bus_pkg::mpu_data_t  mpu_data_out,
  output gfx_bus_pkg::mem_write_t mem_wr,
  output logic                    display_en,
  input  logic                    frame_start,
  input  logic                    underrun
);

  gfx_bus_pkg::region_e     region;
  gfx_bus_pkg::mpu_addr_t   rel_addr;     // Address minus region base
  gfx_bus_pkg::mem_offset_t offset;
  gfx_bus_pkg::mem_write_t  next_wr;
  gfx_bus_pkg::mem_write_t  wr_payload;
  logic                     wr_valid;
  logic                     reg_we;
  gfx_bus_pkg::mpu_data_t   ctrl;
  logic                     underrun_seen;
  gfx_bus_pkg::mpu_data_t   frames;

  // Wrapping subtract makes one compare cover both bounds
  function automatic logic in_region(gfx_bus_pkg::mpu_addr_t addr,
                                     gfx_bus_pkg::mpu_addr_t base,
                                     gfx_bus_pkg::mpu_addr_t len);
    return (addr - base) < len;
  endfunction

  always_comb begin
    region   = gfx_bus_pkg::REGION_NONE;
    rel_addr = mpu_addr;
    if (in_region(mpu_addr, gfx_bus_pkg::REG_BASE, gfx_bus_pkg::REG_LEN)) begin
      region   = gfx_bus_pkg::REGION_REGS;
      rel_addr = mpu_addr - gfx_bus_pkg::REG_BASE;
    end else if (in_region(mpu_addr, gfx_bus_pkg::PAL_BASE, gfx_bus_pkg::PAL_LEN)) begin
      region   = gfx_bus_pkg::REGION_PAL;
      rel_addr = mpu_addr - gfx_bus_pkg::PAL_BASE;
    end else if (in_region(mpu_addr, gfx_bus_pkg::MAP_BASE, gfx_bus_pkg::MAP_LEN)) begin
      region   = gfx_bus_pkg::REGION_MAP;
      rel_addr = mpu_addr - gfx_bus_pkg::MAP_BASE;
    end else if (in_region(mpu_addr, gfx_bus_pkg::VRAM_BASE, gfx_bus_pkg::VRAM_LEN)) begin
      region   = gfx_bus_pkg::REGION_VRAM;
      rel_addr = mpu_addr - gfx_bus_pkg::VRAM_BASE;
    end
  end

  assign offset = gfx_bus_pkg::mem_offset_t'(rel_addr);

  always_comb begin
    next_wr.we     = !mpu_en_n && !mpu_wr_n && (region != gfx_bus_pkg::REGION_NONE);
    next_wr.region = region;
    next_wr.offset = offset;
    next_wr.data   = mpu_data_in;
    next_wr.be     = ~mpu_be_n;  // Strobes go active high here
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= next_wr.we;
    end
  end

  always_ff @(posedge clk) begin
    wr_payload <= next_wr;
  end

  always_comb begin
    mem_wr    = wr_payload;
    mem_wr.we = wr_valid;
  end

  // Registers take the packet one edge after the bus is sampled
  assign reg_we = mem_wr.we && (mem_wr.region == gfx_bus_pkg::REGION_REGS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl          <= '0;
      underrun_seen <= 1'b0;
      frames        <= '0;
    end else begin
      if (reg_we && mem_wr.offset == gfx_bus_pkg::REG_CTRL)
        ctrl <= gfx_bus_pkg::merge_bytes(ctrl, mem_wr.data, mem_wr.be);
      if (underrun)
        underrun_seen <= 1'b1;       // Sticky until reset
      if (frame_start)
        frames <= frames + 1'b1;     // Wraps
    end
  end

  assign display_en = ctrl[0];

  always_comb begin
    mpu_data_out = '0;
    if (!mpu_en_n && !mpu_rd_n && region == gfx_bus_pkg::REGION_REGS) begin
      case (offset)
        gfx_bus_pkg::REG_CTRL:   mpu_data_out = ctrl;
        gfx_bus_pkg::REG_STATUS: mpu_data_out = {15'd0, underrun_seen};
        gfx_bus_pkg::REG_FRAMES: mpu_data_out = frames;
        default:                 mpu_data_out = '0;
      endcase
    end
  end

endmodule

//--- pixel_fifo.sv
/* First-word-fall-through FIFO of palette indices with level count */
`timescale 1ns/10ps

module pixel_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  gfx_video_pkg::pix_index_t  push_data,
  input  logic                       pop,
  output gfx_video_pkg::pix_index_t  pop_data,
  output logic                       empty,
  output gfx_video_pkg::fifo_level_t level
);

  gfx_video_pkg::pix_index_t fifo_mem [gfx_video_pkg::FIFO_DEPTH];
  gfx_video_pkg::fifo_ptr_t  wr_ptr;
  gfx_video_pkg::fifo_ptr_t  rd_ptr;
  logic                      do_pop;

  assign empty    = (level == '0);
  assign do_pop   = pop && !empty;  // Pop of an empty FIFO is dropped
  assign pop_data = fifo_mem[rd_ptr];  // Head shows without a pop

  always_ff @(posedge clk) begin
    if (push)
      fifo_mem[wr_ptr] <= push_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the tile graphics testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gfx -f all.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_gfx +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- scan_out.sv
/* Scan-out: raster counters, sync decode, palette RAM,
   registered 6:6:6 RGB output, frame start and underrun pulses */
`timescale 1ns/10ps

module scan_out (
  input  logic                      clk,
  input  logic                      rst_n,
  input  gfx_bus_pkg::mem_write_t   mem_wr,
  input  logic                      display_en,
  input  gfx_video_pkg::pix_index_t pop_data,
  input  logic                      empty,
  output logic                      pop,
  output logic                      frame_start,
  output logic                      underrun,
  output logic                      vga_hsync,
  output logic                      vga_vsync,
  output gfx_video_pkg::rgb_t       vga_rgb
);

  gfx_video_pkg::rgb565_t    pal_ram [gfx_bus_pkg::PAL_LEN];
  gfx_video_pkg::pix_index_t pal_wr_addr;
  gfx_video_pkg::hcount_t    h;
  gfx_video_pkg::vcount_t    v;
  logic                      visible;
  logic                      hsync_zone;
  logic                      vsync_zone;
  gfx_video_pkg::rgb565_t    pal_colour;
  gfx_video_pkg::rgb_t       pix_rgb;

  assign pal_wr_addr = gfx_video_pkg::pix_index_t'(mem_wr.offset);

  always_ff @(posedge clk) begin
    if (mem_wr.we && mem_wr.region == gfx_bus_pkg::REGION_PAL)
      pal_ram[pal_wr_addr] <= gfx_bus_pkg::merge_bytes(pal_ram[pal_wr_addr],
                                                       mem_wr.data, mem_wr.be);
  end

  // Start in vertical blank so the fetcher can fill the FIFO
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h <= '0;
      v <= gfx_video_pkg::V_RESET_LINE;
    end else if (h == gfx_video_pkg::H_TOTAL - 1'b1) begin
      h <= '0;
      v <= (v == gfx_video_pkg::V_TOTAL - 1'b1) ? '0 : v + 1'b1;
    end else begin
      h <= h + 1'b1;
    end
  end

  assign visible    = (h < gfx_video_pkg::H_ACTIVE) && (v < gfx_video_pkg::V_ACTIVE);
  assign hsync_zone = (h >= gfx_video_pkg::H_SYNC_START) && (h <= gfx_video_pkg::H_SYNC_END);
  assign vsync_zone = (v >= gfx_video_pkg::V_SYNC_START) && (v <= gfx_video_pkg::V_SYNC_END);

  assign pop         = visible;          // One pixel per visible clock
  assign underrun    = visible && empty;
  assign frame_start = (h == '0) && (v == gfx_video_pkg::V_SYNC_START);

  assign pal_colour = pal_ram[pop_data];

  // RGB565 to 6:6:6, red and blue get their MSB repeated below the LSB
  assign pix_rgb = {pal_colour[15:11], pal_colour[15],
                    pal_colour[10:5],
                    pal_colour[4:0], pal_colour[4]};

  // Outputs lag the counters by one clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_rgb   <= '0;
    end else begin
      vga_hsync <= !hsync_zone;  // Active low
      vga_vsync <= !vsync_zone;
      vga_rgb   <= (display_en && visible && !empty) ? pix_rgb : '0;
    end
  end

endmodule

//--- tb_gfx.sv
/* Testbench: clock, reset, MPU bus tasks, LFSR memory fill,
   shadow memories, raster position model and pixel checks */
`timescale 1ns/10ps

module tb_gfx;

  localparam int          CLK_PERIOD = 100;
  localparam int          WAIT_LIMIT = 2000;   // Cycles, over two frames
  localparam int          RUN_LIMIT  = 20000;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  logic                   clk;
  logic                   rst_n;
  logic                   mpu_en_n;
  logic                   mpu_rd_n;
  logic                   mpu_wr_n;
  logic [1:0]             mpu_be_n;
  logic [15:0]            mpu_addr;
  logic [15:0]            mpu_data_in;
  logic [15:0]            mpu_data_out;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic [17:0]            vga_rgb;

  logic [15:0]            pal_shadow [16];
  logic [15:0]            map_shadow [8];
  logic [15:0]            vram_shadow [256];
  logic [15:0]            ctrl_shadow;
  logic [31:0]            lfsr_state;
  gfx_video_pkg::hcount_t model_h;
  gfx_video_pkg::vcount_t model_v;
  gfx_video_pkg::hcount_t shown_h;   // Position on the outputs now
  gfx_video_pkg::vcount_t shown_v;
  logic [17:0]            pixel_expected;
  logic                   check_pixels;
  logic                   vsync_prev;
  logic [15:0]            vsync_falls;
  int                     mismatches;
  int                     timeouts;
  logic                   run_done;

  gfx_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [15:0] lfsr_word(int nbits);
    logic [15:0] value;
    int          i;
    value = '0;
    for (i = 0; i < nbits; i++) begin
      value      = {value[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
    end
    return value;
  endfunction

  // be_n is the bus strobe, low selects a byte lane
  function automatic logic [15:0] merge_lanes(logic [15:0] old_word, logic [15:0] new_word,
                                              logic [1:0] be_n);
    return {be_n[1] ? old_word[15:8] : new_word[15:8],
            be_n[0] ? old_word[7:0] : new_word[7:0]};
  endfunction

  function automatic logic [17:0] expected_colour(int x, int y);
    logic [3:0]  tile;
    logic [15:0] word;
    logic [3:0]  pix;
    logic [15:0] c;
    tile = map_shadow[(y / 8) * 4 + x / 8][3:0];
    word = vram_shadow[tile * 16 + (y % 8) * 2 + (x % 8) / 4];
    pix  = 4'(word >> (4 * (x % 4)));
    c    = pal_shadow[pix];
    return {c[15:11], c[15], c[10:5], c[4:0], c[4]};  // MSB copied below red and blue
  endfunction

  task automatic mpu_write(input logic [15:0] addr, input logic [15:0] data,
                           input logic [1:0] be_n);
    @(negedge clk);
    mpu_addr    = addr;
    mpu_data_in = data;
    mpu_be_n    = be_n;
    mpu_en_n    = 1'b0;
    mpu_wr_n    = 1'b0;
    @(negedge clk);
    mpu_en_n = 1'b1;
    mpu_wr_n = 1'b1;
    mpu_be_n = 2'b11;
    @(negedge clk);  // Packet lands one edge later
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [15:0] expected,
                            input string name);
    logic [15:0] value;
    @(negedge clk);
    mpu_addr = addr;
    mpu_en_n = 1'b0;
    mpu_rd_n = 1'b0;
    #(CLK_PERIOD / 4);
    value = mpu_data_out;
    @(negedge clk);
    mpu_en_n = 1'b1;
    mpu_rd_n = 1'b1;
    assert (value == expected) else begin
      mismatches++;
      $display("MISMATCH mpu_data_out (%s): got %h expected %h", name, value, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s", what);
    run_done = 1'b1;
    forever @(negedge clk);  // Run control ends the simulation
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    int   n;
    prev = vga_vsync;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge clk);
      if (prev && !vga_vsync)
        return;
      prev = vga_vsync;
    end
    report_timeout("vsync to fall");
  endtask

  task automatic check_registers();
    logic [15:0] ctrl_addr;
    logic [15:0] data;
    logic [1:0]  be_n;
    int          i;
    ctrl_addr = gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_CTRL);
    wait_vsync_fall();  // Far from the next frame count update
    check_read(ctrl_addr, ctrl_shadow, "ctrl");
    for (i = 0; i < 4; i++) begin
      be_n = 2'(3 - i);
      data = (i == 3) ? 16'h5678 : (i == 2) ? 16'hABCD : (i == 1) ? 16'h1234 : 16'hFFFF;
      mpu_write(ctrl_addr, data, be_n);
      ctrl_shadow = merge_lanes(ctrl_shadow, data, be_n);
      check_read(ctrl_addr, ctrl_shadow, "ctrl");
    end
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_STATUS), 16'h0000, "status");
    mpu_write(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_STATUS), 16'hFFFF, 2'b00);
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_STATUS), 16'h0000, "status");
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_FRAMES), vsync_falls, "frames");
    mpu_write(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_FRAMES), 16'hFFFF, 2'b00);
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_FRAMES), vsync_falls, "frames");
  endtask

  task automatic fill_memories();
    int i;
    for (i = 0; i < 16; i++) begin
      pal_shadow[i] = lfsr_word(16);
      mpu_write(gfx_bus_pkg::PAL_BASE + 16'(i), pal_shadow[i], 2'b00);
    end
    for (i = 0; i < 8; i++) begin
      map_shadow[i] = lfsr_word(16);
      mpu_write(gfx_bus_pkg::MAP_BASE + 16'(i), map_shadow[i], 2'b00);
    end
    for (i = 0; i < 256; i++) begin
      vram_shadow[i] = lfsr_word(16);
      mpu_write(gfx_bus_pkg::VRAM_BASE + 16'(i), vram_shadow[i], 2'b00);
    end
  endtask

  // Follows the scan-out counters, outputs trail them by one clock
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_h <= '0;
      model_v <= gfx_video_pkg::V_RESET_LINE;
      shown_h <= '0;
      shown_v <= gfx_video_pkg::V_RESET_LINE;
    end else begin
      shown_h <= model_h;
      shown_v <= model_v;
      if (model_h == gfx_video_pkg::H_TOTAL - 1'b1) begin
        model_h <= '0;
        model_v <= (model_v == gfx_video_pkg::V_TOTAL - 1'b1) ? '0 : model_v + 1'b1;
      end else begin
        model_h <= model_h + 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && check_pixels) begin
      if (shown_h < gfx_video_pkg::H_ACTIVE && shown_v < gfx_video_pkg::V_ACTIVE
          && ctrl_shadow[0])
        pixel_expected = expected_colour(int'(shown_h), int'(shown_v));
      else
        pixel_expected = '0;
      assert (vga_rgb == pixel_expected) else begin
        mismatches++;
        $display("MISMATCH vga_rgb at h %0d line %0d: got %h expected %h",
                 shown_h, shown_v, vga_rgb, pixel_expected);
      end
    end
    if (rst_n && vsync_prev && !vga_vsync)
      vsync_falls = vsync_falls + 1'b1;
    vsync_prev = vga_vsync;
  end

  initial begin
    logic [15:0] addr;
    logic [15:0] data;
    rst_n        = 1'b0;
    mpu_en_n     = 1'b1;
    mpu_rd_n     = 1'b1;
    mpu_wr_n     = 1'b1;
    mpu_be_n     = 2'b11;
    mpu_addr     = '0;
    mpu_data_in  = '0;
    ctrl_shadow  = '0;
    lfsr_state   = 32'h8d15_f0dd;
    check_pixels = 1'b0;
    vsync_prev   = 1'b1;
    vsync_falls  = '0;
    mismatches   = 0;
    timeouts     = 0;
    run_done     = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_registers();
    fill_memories();
    wait_vsync_fall();
    check_pixels = 1'b1;  // Whole frame with display off
    wait_vsync_fall();
    check_pixels = 1'b0;
    ctrl_shadow = ctrl_shadow | 16'h0001;
    mpu_write(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_CTRL), ctrl_shadow, 2'b00);
    wait_vsync_fall();
    check_pixels = 1'b1;
    wait_vsync_fall();
    wait_vsync_fall();
    check_pixels = 1'b0;
    // High byte of a displayed pattern word, low byte of one palette entry
    addr = 16'(map_shadow[0][3:0]) * 16'd16;
    data = lfsr_word(16);
    mpu_write(gfx_bus_pkg::VRAM_BASE + addr, data, 2'b01);
    vram_shadow[addr] = merge_lanes(vram_shadow[addr], data, 2'b01);
    addr = lfsr_word(4);
    data = lfsr_word(16);
    mpu_write(gfx_bus_pkg::PAL_BASE + addr, data, 2'b10);
    pal_shadow[addr] = merge_lanes(pal_shadow[addr], data, 2'b10);
    wait_vsync_fall();
    check_pixels = 1'b1;
    wait_vsync_fall();
    check_pixels = 1'b0;
    @(posedge clk);  // Fall count of this negedge is settled
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_FRAMES), vsync_falls, "frames");
    check_read(gfx_bus_pkg::REG_BASE + 16'(gfx_bus_pkg::REG_STATUS), 16'h0000, "status");
    run_done = 1'b1;
  end

  initial begin : run_control
    int cycles;
    cycles = 0;
    while (!run_done && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!run_done) begin
      timeouts++;
      $display("Timeout: test sequence did not complete");
    end
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, dut_i.props_i.fail_count);
    if (mismatches == 0 && timeouts == 0 && dut_i.props_i.fail_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- tile_fetcher.sv
/* Tile fetcher: tile map and pattern RAMs, raster-order position walk
   and the two-stage map/pattern pipeline that feeds the pixel FIFO */
`timescale 1ns/10ps

module tile_fetcher (
  input  logic                       clk,
  input  logic                       rst_n,
  input  gfx_bus_pkg::mem_write_t    mem_wr,
  output logic                       push,
  output gfx_video_pkg::pix_index_t  push_data,
  input  gfx_video_pkg::fifo_level_t fifo_level
);

  gfx_bus_pkg::mpu_data_t map_ram [gfx_bus_pkg::MAP_LEN];
  gfx_bus_pkg::mpu_data_t pat_ram [gfx_bus_pkg::VRAM_LEN];

  gfx_video_pkg::map_addr_t   map_wr_addr;
  gfx_video_pkg::hcount_t     fx;         // Next position to issue
  gfx_video_pkg::vcount_t     fy;
  gfx_video_pkg::fifo_level_t occupancy;
  logic                       issue;
  gfx_video_pkg::map_addr_t   map_addr;

  logic                       s1_valid;
  gfx_video_pkg::tile_index_t s1_tile;
  gfx_video_pkg::hcount_t     s1_x;
  gfx_video_pkg::vcount_t     s1_y;
  gfx_bus_pkg::mem_offset_t   pat_addr;
  gfx_bus_pkg::mpu_data_t     pat_word;

  logic                       s2_valid;
  gfx_video_pkg::pix_index_t  s2_pix;

  assign map_wr_addr = gfx_video_pkg::map_addr_t'(mem_wr.offset);

  always_ff @(posedge clk) begin
    if (mem_wr.we && mem_wr.region == gfx_bus_pkg::REGION_MAP)
      map_ram[map_wr_addr] <= gfx_bus_pkg::merge_bytes(map_ram[map_wr_addr],
                                                       mem_wr.data, mem_wr.be);
    if (mem_wr.we && mem_wr.region == gfx_bus_pkg::REGION_VRAM)
      pat_ram[mem_wr.offset] <= gfx_bus_pkg::merge_bytes(pat_ram[mem_wr.offset],
                                                         mem_wr.data, mem_wr.be);
  end

  // FIFO level plus pixels still in the pipeline
  assign occupancy = fifo_level + gfx_video_pkg::fifo_level_t'(s1_valid)
                   + gfx_video_pkg::fifo_level_t'(s2_valid);
  assign issue     = occupancy < gfx_video_pkg::FIFO_DEPTH;

  // Visible area only, wraps to (0, 0) after the last pixel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fx <= '0;
      fy <= '0;
    end else if (issue) begin
      if (fx == gfx_video_pkg::H_ACTIVE - 1'b1) begin
        fx <= '0;
        fy <= (fy == gfx_video_pkg::V_ACTIVE - 1'b1) ? '0 : fy + 1'b1;
      end else begin
        fx <= fx + 1'b1;
      end
    end
  end

  assign map_addr = gfx_video_pkg::map_addr_t'((fy / gfx_video_pkg::TILE_SIZE)
                  * gfx_video_pkg::MAP_COLS + fx / gfx_video_pkg::TILE_SIZE);

  // Word holding the pixel within the tile's pattern block
  assign pat_addr = gfx_bus_pkg::mem_offset_t'(s1_tile * gfx_video_pkg::WORDS_PER_TILE
                  + (s1_y % gfx_video_pkg::TILE_SIZE) * gfx_video_pkg::WORDS_PER_ROW
                  + (s1_x % gfx_video_pkg::TILE_SIZE) / gfx_video_pkg::PIX_PER_WORD);
  assign pat_word = pat_ram[pat_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_tile <= gfx_video_pkg::tile_index_t'(map_ram[map_addr]);  // Stage 1 map read
    s1_x    <= fx;
    s1_y    <= fy;
    s2_pix  <= pat_word[gfx_video_pkg::PIX_BITS * (s1_x % gfx_video_pkg::PIX_PER_WORD)
                        +: gfx_video_pkg::PIX_BITS];               // Stage 2 nibble
  end

  assign push      = s2_valid;
  assign push_data = s2_pix;

endmodule
